// File: logic/scope_consts.svh
/*
 * Trace tap constants: serial word width, probe and trigger widths,
 * trace depth, counter widths and the scope id
 */
`ifndef SCOPE_CONSTS_SVH
`define SCOPE_CONSTS_SVH

`define SCOPE_TX_DATAW   32
`define SCOPE_PROBEW     16
`define SCOPE_XTRIGW     4
`define SCOPE_HTRIGW     2
`define SCOPE_DATAW      (`SCOPE_PROBEW + `SCOPE_XTRIGW + `SCOPE_HTRIGW)

`define SCOPE_DEPTH      16     // power of two
`define SCOPE_ADDRW      4
`define SCOPE_SIZEW      5      // holds 0..DEPTH

`define SCOPE_IDLE_CTRW  8
`define SCOPE_IDW        8
`define SCOPE_ID         8'h2a

`endif

// File: logic/scope_pkg.sv
/*
 * Trace tap types: record and controller state machines,
 * command opcodes and response kinds
 */
`default_nettype none

package scope_pkg;

    typedef enum logic [1:0] {
        TAP_IDLE,
        TAP_RUN,
        TAP_DONE
    } tap_state_t;

    typedef enum logic [1:0] {
        CTRL_IDLE,
        CTRL_RECV,
        CTRL_CMD,
        CTRL_SEND
    } ctrl_state_t;

    typedef enum logic [2:0] {
        CMD_GET_WIDTH = 3'd0,
        CMD_GET_COUNT = 3'd1,
        CMD_GET_START = 3'd2,
        CMD_GET_DATA  = 3'd3,
        CMD_SET_START = 3'd4,
        CMD_SET_STOP  = 3'd5,
        CMD_SET_DEPTH = 3'd6
    } cmd_t;

    typedef enum logic [1:0] {
        SEND_WIDTH,
        SEND_COUNT,
        SEND_START,
        SEND_DATA
    } send_t;

endpackage

`default_nettype wire

// File: logic/capture_if.sv
/*
 * Link between trace capture and the command controller:
 * record control and depth one way, count, timestamp and readout back
 */
`default_nettype none

`include "scope_consts.svh"

interface capture_if;

    logic                          cmd_start;   // one-cycle pulses
    logic                          cmd_stop;
    logic [`SCOPE_SIZEW-1:0]       depth;       // end address
    logic [`SCOPE_ADDRW-1:0]       raddr;

    logic [`SCOPE_SIZEW-1:0]       count;
    logic [`SCOPE_TX_DATAW-1:0]    start_time;
    logic [`SCOPE_DATAW-1:0]       rd_data;     // one cycle after raddr
    logic [`SCOPE_IDLE_CTRW-1:0]   rd_delta;

    modport capture (
        input  cmd_start, cmd_stop, depth, raddr,
        output count, start_time, rd_data, rd_delta
    );

    modport ctrl (
        output cmd_start, cmd_stop, depth, raddr,
        input  count, start_time, rd_data, rd_delta
    );

endinterface

`default_nettype wire

// File: logic/trace_ram.sv
/*
 * Simple dual-port trace memory, one write and one registered read port
 */
`default_nettype none

module trace_ram #(
    parameter int DATAW = 8,
    parameter int DEPTH = 16,
    localparam int ADDRW = (DEPTH > 1) ? $clog2(DEPTH) : 1
) (
    input  wire              clk,
    input  wire              reset,
    input  wire              write,
    input  wire [ADDRW-1:0]  waddr,
    input  wire [DATAW-1:0]  wdata,
    input  wire [ADDRW-1:0]  raddr,
    output logic [DATAW-1:0] rdata
);

    logic [DATAW-1:0] mem [DEPTH];

    always_ff @(posedge clk) begin
        if (write) begin
            mem[waddr] <= wdata;
        end
    end

    // read sees the old word when both ports hit the same address
    always_ff @(posedge clk) begin
        if (reset) begin
            rdata <= '0;
        end else begin
            rdata <= mem[raddr];
        end
    end

endmodule

`default_nettype wire

// File: logic/trace_capture.sv
/*
 * Trace capture: free-running timestamp, record FSM, capture decision
 * on trigger change or high trigger, idle counting, sample and idle RAMs
 */
`default_nettype none

`include "scope_consts.svh"

module trace_capture (
    input  wire                       clk,
    input  wire                       reset,
    input  wire                       start,
    input  wire                       stop,
    input  wire [`SCOPE_XTRIGW-1:0]   xtriggers,
    input  wire [`SCOPE_HTRIGW-1:0]   htriggers,
    input  wire [`SCOPE_PROBEW-1:0]   probes,
    capture_if.capture                cap
);

    localparam int SIZEW    = `SCOPE_SIZEW;
    localparam int IDLEW    = `SCOPE_IDLE_CTRW;
    localparam int TSW      = `SCOPE_TX_DATAW;
    localparam int IDLE_MAX = (2 ** IDLEW) - 1;

    scope_pkg::tap_state_t tap_state;

    logic [TSW-1:0]           timestamp;
    logic [TSW-1:0]           start_time;
    logic [SIZEW-1:0]         count;
    logic [IDLEW-1:0]         delta;
    logic [`SCOPE_XTRIGW-1:0] prev_xtrig;
    logic [`SCOPE_HTRIGW-1:0] prev_htrig;
    logic                     dflush;       // forces the next capture

    logic                     halt;
    logic                     do_capture;
    logic                     write_en;
    logic [`SCOPE_DATAW-1:0]  data_in;

    assign data_in    = {probes, xtriggers, htriggers};
    assign halt       = stop || cap.cmd_stop || (count >= cap.depth);
    assign do_capture = dflush || (xtriggers != prev_xtrig)
                        || (htriggers != prev_htrig) || (|htriggers);
    assign write_en   = (tap_state == scope_pkg::TAP_RUN) && !halt && do_capture;

    always_ff @(posedge clk) begin
        if (reset) begin
            timestamp <= '0;
        end else begin
            timestamp <= timestamp + TSW'(1);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            tap_state  <= scope_pkg::TAP_IDLE;
            start_time <= '0;
            count      <= '0;
            delta      <= '0;
            prev_xtrig <= '0;
            prev_htrig <= '0;
            dflush     <= 1'b0;
        end else begin
            case (tap_state)
                scope_pkg::TAP_IDLE: begin
                    if (start || cap.cmd_start) begin
                        tap_state  <= scope_pkg::TAP_RUN;
                        start_time <= timestamp;
                        dflush     <= 1'b1;     // first cycle always stored
                    end
                end
                scope_pkg::TAP_RUN: begin
                    dflush <= 1'b0;
                    if (halt) begin
                        tap_state <= scope_pkg::TAP_DONE;
                    end else begin
                        if (do_capture) begin
                            count <= count + SIZEW'(1);
                            delta <= '0;
                        end else begin
                            delta  <= delta + IDLEW'(1);
                            dflush <= (delta == IDLEW'(IDLE_MAX - 1)); // saturating gap
                        end
                        prev_xtrig <= xtriggers;
                        prev_htrig <= htriggers;
                    end
                end
                default: ;  // done until reset
            endcase
        end
    end

    trace_ram #(
        .DATAW (`SCOPE_DATAW),
        .DEPTH (`SCOPE_DEPTH)
    ) data_store (
        .clk   (clk),
        .reset (reset),
        .write (write_en),
        .waddr (count[`SCOPE_ADDRW-1:0]),
        .wdata (data_in),
        .raddr (cap.raddr),
        .rdata (cap.rd_data)
    );

    trace_ram #(
        .DATAW (IDLEW),
        .DEPTH (`SCOPE_DEPTH)
    ) delta_store (
        .clk   (clk),
        .reset (reset),
        .write (write_en),
        .waddr (count[`SCOPE_ADDRW-1:0]),
        .wdata (delta),
        .raddr (cap.raddr),
        .rdata (cap.rd_delta)
    );

    assign cap.count      = count;
    assign cap.start_time = start_time;

endmodule

`default_nettype wire

// File: logic/scope_ctrl.sv
/*
 * Command controller: serial receiver with id check, command decode,
 * start and stop delay timers, depth register, serial response sender
 */
`default_nettype none

`include "scope_consts.svh"

module scope_ctrl (
    input  wire        clk,
    input  wire        reset,
    input  wire        bus_in,
    output logic       bus_out,
    capture_if.ctrl    cap
);

    localparam int TXW   = `SCOPE_TX_DATAW;
    localparam int IDW   = `SCOPE_IDW;
    localparam int ARGW  = TXW - 3 - IDW;
    localparam int CNTW  = $clog2(TXW);
    localparam int SIZEW = `SCOPE_SIZEW;

    scope_pkg::ctrl_state_t ctrl_state;
    scope_pkg::cmd_t        cmd;
    scope_pkg::send_t       send_kind;

    logic [TXW-1:0]  rx_buf;
    logic [TXW-1:0]  rx_next;
    logic [TXW-1:0]  tx_buf;
    logic [TXW-1:0]  resp_word;
    logic [CNTW-1:0] bit_ctr;
    logic [TXW-1:0]  start_delay;
    logic [TXW-1:0]  stop_delay;
    logic [IDW-1:0]  rx_id;
    logic [ARGW-1:0] cmd_arg;
    logic            is_get;
    logic            is_read_data;  // next data word is a sample
    logic            bus_out_r;

    assign rx_next = {rx_buf[TXW-2:0], bus_in};
    assign rx_id   = rx_next[3 +: IDW];
    assign cmd     = scope_pkg::cmd_t'(rx_buf[2:0]);
    assign cmd_arg = rx_buf[TXW-1 -: ARGW];

    always_comb begin
        is_get    = 1'b1;
        send_kind = scope_pkg::SEND_WIDTH;
        case (cmd)
            scope_pkg::CMD_GET_WIDTH: ;
            scope_pkg::CMD_GET_COUNT: send_kind = scope_pkg::SEND_COUNT;
            scope_pkg::CMD_GET_START: send_kind = scope_pkg::SEND_START;
            scope_pkg::CMD_GET_DATA:  send_kind = scope_pkg::SEND_DATA;
            default:                  is_get = 1'b0;
        endcase

        case (send_kind)
            scope_pkg::SEND_WIDTH: resp_word = TXW'(`SCOPE_DATAW);
            scope_pkg::SEND_COUNT: resp_word = TXW'(cap.count);
            scope_pkg::SEND_START: resp_word = cap.start_time;
            default:               resp_word = is_read_data ? TXW'(cap.rd_data)
                                                            : TXW'(cap.rd_delta);
        endcase
    end

    // shift registers
    always_ff @(posedge clk) begin
        if (ctrl_state == scope_pkg::CTRL_RECV) begin
            rx_buf <= rx_next;
        end
        if (ctrl_state == scope_pkg::CTRL_CMD && is_get) begin
            tx_buf <= resp_word;    // snapshot, sent MSB first
        end else if (ctrl_state == scope_pkg::CTRL_SEND) begin
            tx_buf <= tx_buf << 1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ctrl_state    <= scope_pkg::CTRL_IDLE;
            bit_ctr       <= '0;
            start_delay   <= '0;
            stop_delay    <= '0;
            cap.cmd_start <= 1'b0;
            cap.cmd_stop  <= 1'b0;
            cap.depth     <= SIZEW'(`SCOPE_DEPTH);
            cap.raddr     <= '0;
            is_read_data  <= 1'b0;
            bus_out_r     <= 1'b0;
        end else begin
            bus_out_r <= 1'b0;

            if (start_delay != '0) begin
                start_delay <= start_delay - TXW'(1);
            end
            if (stop_delay != '0) begin
                stop_delay <= stop_delay - TXW'(1);
            end
            cap.cmd_start <= (start_delay == TXW'(1));
            cap.cmd_stop  <= (stop_delay == TXW'(1));

            case (ctrl_state)
                scope_pkg::CTRL_IDLE: begin
                    if (bus_in) begin   // start bit
                        bit_ctr    <= CNTW'(TXW - 1);
                        ctrl_state <= scope_pkg::CTRL_RECV;
                    end
                end
                scope_pkg::CTRL_RECV: begin
                    bit_ctr <= bit_ctr - CNTW'(1);
                    if (bit_ctr == '0) begin
                        // other ids dropped silently
                        ctrl_state <= (rx_id == `SCOPE_ID) ? scope_pkg::CTRL_CMD
                                                           : scope_pkg::CTRL_IDLE;
                    end
                end
                scope_pkg::CTRL_CMD: begin
                    ctrl_state <= scope_pkg::CTRL_IDLE;
                    case (cmd)
                        scope_pkg::CMD_SET_START: begin
                            start_delay   <= TXW'(cmd_arg);
                            cap.cmd_start <= (cmd_arg == '0);
                        end
                        scope_pkg::CMD_SET_STOP: begin
                            stop_delay   <= TXW'(cmd_arg);
                            cap.cmd_stop <= (cmd_arg == '0);
                        end
                        scope_pkg::CMD_SET_DEPTH: cap.depth <= SIZEW'(cmd_arg);
                        default: ;
                    endcase
                    if (is_get) begin
                        bit_ctr    <= CNTW'(TXW - 1);
                        bus_out_r  <= 1'b1;
                        ctrl_state <= scope_pkg::CTRL_SEND;
                    end
                    if (cmd == scope_pkg::CMD_GET_DATA) begin
                        if (is_read_data) begin
                            cap.raddr <= cap.raddr + `SCOPE_ADDRW'(1); // entry done
                        end
                        is_read_data <= !is_read_data;
                    end
                end
                scope_pkg::CTRL_SEND: begin
                    bus_out_r <= tx_buf[TXW-1];
                    bit_ctr   <= bit_ctr - CNTW'(1);
                    if (bit_ctr == '0) begin
                        ctrl_state <= scope_pkg::CTRL_IDLE;
                    end
                end
                default: ctrl_state <= scope_pkg::CTRL_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            bus_out <= 1'b0;
        end else begin
            bus_out <= bus_out_r;
        end
    end

endmodule

`default_nettype wire

// File: logic/scope_tap.sv
/*
 * Trace tap top level: trace capture and command controller
 * joined by the capture interface
 */
`default_nettype none

`include "scope_consts.svh"

module scope_tap (
    input  wire                      clk,
    input  wire                      reset,
    input  wire                      start,
    input  wire                      stop,
    input  wire [`SCOPE_XTRIGW-1:0]  xtriggers,
    input  wire [`SCOPE_HTRIGW-1:0]  htriggers,
    input  wire [`SCOPE_PROBEW-1:0]  probes,
    input  wire                      bus_in,
    output wire                      bus_out
);

    capture_if cap_bus ();

    trace_capture u_capture (
        .clk       (clk),
        .reset     (reset),
        .start     (start),
        .stop      (stop),
        .xtriggers (xtriggers),
        .htriggers (htriggers),
        .probes    (probes),
        .cap       (cap_bus.capture)
    );

    scope_ctrl u_ctrl (
        .clk     (clk),
        .reset   (reset),
        .bus_in  (bus_in),
        .bus_out (bus_out),
        .cap     (cap_bus.ctrl)
    );

endmodule

`default_nettype wire

// File: bench/scope_bus_tasks.svh
/*
 * Serial bus tasks for the trace tap testbench: shift a command word
 * in on bus_in, collect a 32-bit response from bus_out with a timeout
 */
`ifndef SCOPE_BUS_TASKS_SVH
`define SCOPE_BUS_TASKS_SVH

// start bit, then 32 bits MSB first
task automatic send_word(input logic [31:0] word);
    @(posedge clk);
    bus_in <= 1'b1;
    for (int i = 31; i >= 0; i--) begin
        @(posedge clk);
        bus_in <= word[i];
    end
    @(posedge clk);
    bus_in <= 1'b0;
endtask

task automatic send_cmd(input scope_pkg::cmd_t op, input logic [7:0] id,
                        input logic [20:0] arg);
    send_word({arg, id, 3'(op)});
endtask

task automatic get_word(input scope_pkg::cmd_t op, output logic [31:0] word);
    int waited;
    word = 'x;
    send_cmd(op, `SCOPE_ID, '0);
    waited = 0;
    @(negedge clk);
    while (bus_out !== 1'b1 && waited < 20) begin  // start bit due a few cycles on
        @(negedge clk);
        waited++;
    end
    if (bus_out !== 1'b1) begin
        $display("timeout: no response start bit for command %s", op.name());
        errors++;
    end else begin
        for (int i = 0; i < 32; i++) begin
            @(negedge clk);
            word = {word[30:0], bus_out};
        end
    end
endtask

`endif

// File: bench/scope_tap_tb.sv
/*
 * Trace tap testbench: clock and reset, serial commands, a cycle model
 * of the recording rules, checks on width, count, readout and id filter
 */
`default_nettype none

`include "scope_consts.svh"

module scope_tap_tb;

    logic                      clk;
    logic                      reset;
    logic                      start;
    logic                      stop;
    logic [`SCOPE_XTRIGW-1:0]  xtriggers;
    logic [`SCOPE_HTRIGW-1:0]  htriggers;
    logic [`SCOPE_PROBEW-1:0]  probes;
    logic                      bus_in;
    wire                       bus_out;

    int          errors;
    int          errors_base;
    int          tests_run;
    logic [31:0] rng;
    logic [31:0] got_delta [`SCOPE_DEPTH];

    // recording model
    logic                     m_run;
    logic                     m_done;
    logic                     m_flush;
    int                       m_count;
    int                       m_depth;
    int                       m_idle;
    logic [`SCOPE_XTRIGW-1:0] m_prev_x;
    logic [`SCOPE_HTRIGW-1:0] m_prev_h;
    logic [`SCOPE_DATAW-1:0]  m_data [`SCOPE_DEPTH];
    logic [7:0]               m_delta [`SCOPE_DEPTH];

    scope_tap u_scope_tap (
        .clk       (clk),
        .reset     (reset),
        .start     (start),
        .stop      (stop),
        .xtriggers (xtriggers),
        .htriggers (htriggers),
        .probes    (probes),
        .bus_in    (bus_in),
        .bus_out   (bus_out)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

    `include "scope_bus_tasks.svh"

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] v;
        v = s ^ (s << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    task automatic expect_equal(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        assert (got === exp) else begin
            $display("FAIL %s got 0x%h expected 0x%h", name, got, exp);
            errors++;
        end
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        $display("test %0d %s: %0d errors", tests_run, name, errors - errors_base);
        errors_base = errors;
    endtask

    task automatic apply_reset();
        @(posedge clk);
        reset     <= 1'b1;
        start     <= 1'b0;
        stop      <= 1'b0;
        xtriggers <= '0;
        htriggers <= '0;
        probes    <= '0;
        bus_in    <= 1'b0;
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        m_run    = 1'b0;
        m_done   = 1'b0;
        m_flush  = 1'b0;
        m_count  = 0;
        m_depth  = 16;
        m_idle   = 0;
        m_prev_x = '0;
        m_prev_h = '0;
    endtask

    // one sampling edge of the recorder
    task automatic model_edge(input logic [15:0] p, input logic [3:0] x,
                              input logic [1:0] h, input logic st, input logic sp);
        logic hit;
        hit = m_flush || (x != m_prev_x) || (h != m_prev_h) || (|h);
        if (!m_run && !m_done) begin
            if (st) begin
                m_run   = 1'b1;
                m_flush = 1'b1;     // first run cycle always stored
            end
        end else if (m_run) begin
            if (sp || m_count >= m_depth) begin
                m_run  = 1'b0;
                m_done = 1'b1;
            end else begin
                if (hit) begin
                    m_data[m_count]  = {p, x, h};
                    m_delta[m_count] = 8'(m_idle);
                    m_count++;
                    m_idle  = 0;
                    m_flush = 1'b0;
                end else begin
                    m_idle++;
                    m_flush = (m_idle == 255);  // gap full
                end
                m_prev_x = x;
                m_prev_h = h;
            end
        end
    endtask

    // values set here are sampled on the next edge
    task automatic drive_cycle(input logic [15:0] p, input logic [3:0] x,
                               input logic [1:0] h, input logic st, input logic sp,
                               input logic cmd_go);
        @(posedge clk);
        probes    <= p;
        xtriggers <= x;
        htriggers <= h;
        start     <= st;
        stop      <= sp;
        model_edge(p, x, h, st || cmd_go, sp);
    endtask

    task automatic random_inputs(output logic [15:0] p, inout logic [3:0] x,
                                 output logic [1:0] h);
        rng = xorshift32(rng);
        p = rng[21:6];
        if (rng[31:28] == 4'h0) begin
            x = rng[3:0];   // rare change
        end
        h = (rng[27:24] == 4'h0) ? {rng[5], 1'b1} : 2'b00;
    endtask

    task automatic record_random(input int stop_at);
        logic [15:0] p;
        logic [3:0]  x;
        logic [1:0]  h;
        int          n;
        x = 4'h0;
        n = 0;
        while (!m_done && n < 400) begin
            random_inputs(p, x, h);
            drive_cycle(p, x, h, 1'b0, (m_count == stop_at), 1'b0);
            n++;
        end
        if (!m_done) begin
            $display("recording did not end within 400 cycles");
            errors++;
        end
    endtask

    // delta word then sample word per entry
    task automatic check_recording();
        logic [31:0] word;
        get_word(scope_pkg::CMD_GET_COUNT, word);
        expect_equal("count", word, 32'(m_count));
        for (int i = 0; i < m_count; i++) begin
            get_word(scope_pkg::CMD_GET_DATA, word);
            got_delta[i] = word;
            expect_equal($sformatf("delta[%0d]", i), word, {24'h0, m_delta[i]});
            get_word(scope_pkg::CMD_GET_DATA, word);
            expect_equal($sformatf("data[%0d]", i), word, 32'(m_data[i]));
        end
    endtask

    initial begin
        logic [31:0] word;
        logic        seen;
        reset     <= 1'b1;
        start     <= 1'b0;
        stop      <= 1'b0;
        xtriggers <= '0;
        htriggers <= '0;
        probes    <= '0;
        bus_in    <= 1'b0;
        errors      = 0;
        errors_base = 0;
        tests_run   = 0;
        rng         = 32'h79ca023c;

        apply_reset();
        get_word(scope_pkg::CMD_GET_WIDTH, word);
        expect_equal("width", word, 32'd22);
        get_word(scope_pkg::CMD_GET_COUNT, word);
        expect_equal("count", word, 32'd0);
        finish_test("width and empty count");

        apply_reset();
        send_cmd(scope_pkg::CMD_SET_DEPTH, `SCOPE_ID, 21'd8);
        m_depth = 8;
        drive_cycle(16'h0, 4'h0, 2'b00, 1'b0, 1'b0, 1'b0);
        drive_cycle(16'h0, 4'h0, 2'b00, 1'b1, 1'b0, 1'b0);  // start pin pulse
        record_random(-1);
        check_recording();
        finish_test("start pin, depth 8");

        apply_reset();
        send_cmd(scope_pkg::CMD_SET_START, `SCOPE_ID, 21'd0);
        // command runs on the next edge, cmd_start is seen one edge later
        drive_cycle(16'h0, 4'h0, 2'b00, 1'b0, 1'b0, 1'b1);
        record_random(5);
        check_recording();
        get_word(scope_pkg::CMD_GET_COUNT, word);
        assert (word > 32'd0 && word < 32'(m_depth)) else begin
            $display("FAIL count got 0x%h expected below 0x%h", word, m_depth);
            errors++;
        end
        finish_test("command start, stop pin");

        apply_reset();
        drive_cycle(16'h0, 4'h5, 2'b00, 1'b1, 1'b0, 1'b0);
        for (int i = 0; i < 300; i++) begin
            rng = xorshift32(rng);
            drive_cycle(rng[15:0], 4'h5, 2'b00, 1'b0, 1'b0, 1'b0);
        end
        drive_cycle(16'h0, 4'h5, 2'b00, 1'b0, 1'b1, 1'b0);
        check_recording();
        expect_equal("delta[1]", got_delta[1], 32'hff);
        finish_test("idle saturation");

        apply_reset();
        send_cmd(scope_pkg::CMD_SET_START, `SCOPE_ID, 21'd40);
        get_word(scope_pkg::CMD_GET_COUNT, word);
        expect_equal("count", word, 32'd0);
        repeat (100) @(posedge clk);
        get_word(scope_pkg::CMD_GET_COUNT, word);
        assert (word != 32'd0) else begin
            $display("FAIL count got 0x%h expected above 0x0", word);
            errors++;
        end
        finish_test("delayed start");

        apply_reset();
        send_cmd(scope_pkg::CMD_GET_WIDTH, 8'h15, '0);
        seen = 1'b0;
        for (int i = 0; i < 100; i++) begin
            @(negedge clk);
            if (bus_out === 1'b1) begin
                seen = 1'b1;
            end
        end
        assert (!seen) else begin
            $display("response sent for a command with a foreign scope id");
            errors++;
        end
        get_word(scope_pkg::CMD_GET_WIDTH, word);
        expect_equal("width", word, 32'd22);
        finish_test("foreign id dropped");

        $display("tests %0d, errors %0d", tests_run, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: project.f
+incdir+logic
+incdir+bench
logic/scope_pkg.sv
logic/capture_if.sv
logic/trace_ram.sv
logic/trace_capture.sv
logic/scope_ctrl.sv
logic/scope_tap.sv
bench/scope_tap_tb.sv

// File: run_sim.sh
#!/bin/sh
# build the trace tap testbench with Verilator, run it, judge the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f project.f --top-module scope_tap_tb -o scope_tap_sim
./obj_dir/scope_tap_sim | tee sim.log

if grep -q "SIMULATION FAILED" sim.log; then
    echo "run failed"
    exit 1
fi
if ! grep -q "SIMULATION PASSED" sim.log; then
    echo "no result in log"
    exit 1
fi
echo "run passed"
